// ==== logic/dma_defs.svh ====
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// Data path
`define DMA_DATA_BW      16
`define DMA_LINE_WORDS   4
`define DMA_LINE_IDX_BW  2

// DRAM line addressing
`define DMA_GADDR_BW     24

// Signed row offsets, row counts and pitch share this width
`define DMA_ROW_BW       12

// Tile shape
`define DMA_TILE_ROWS    8
`define DMA_TROW_BW      3

`endif

// ==== logic/dma_pkg.sv ====
`include "dma_defs.svh"

package dma_pkg;

	typedef logic [`DMA_LINE_WORDS-1:0][`DMA_DATA_BW-1:0] dma_line_t;

	// Level configuration held stable while a tile is in flight
	typedef struct packed {
		logic [`DMA_GADDR_BW-1:0] base_addr;
		logic [`DMA_ROW_BW-1:0]   pitch;
		logic [`DMA_ROW_BW-1:0]   num_rows;
		logic [`DMA_DATA_BW-1:0]  pad_value;
		logic                     xor_en;
	} tile_cfg_t;

	// row_ofs is two's complement
	typedef struct packed {
		logic [`DMA_ROW_BW-1:0] row_ofs;
	} tile_req_t;

	typedef struct packed {
		logic [`DMA_GADDR_BW-1:0] start_addr;
		logic [`DMA_ROW_BW-1:0]   row_ofs;
	} chunk_t;

	typedef struct packed {
		logic [`DMA_GADDR_BW-`DMA_DATA_BW-1:0] rsvd;
		logic [`DMA_DATA_BW-1:0]               pad_value;
	} cmd_pad_t;

	// Fetch rows carry a line address and pad rows carry the fill word
	typedef union packed {
		logic [`DMA_GADDR_BW-1:0] fetch_addr;
		cmd_pad_t                 pad;
	} cmd_payload_u;

	typedef struct packed {
		logic                    is_pad;
		logic [`DMA_TROW_BW-1:0] trow;
		cmd_payload_u            payload;
	} row_cmd_t;

	typedef struct packed {
		logic [`DMA_TROW_BW-1:0] trow;
		dma_line_t               data;
	} sram_wr_t;

endpackage

// ==== logic/chunk_head.sv ====
`include "dma_defs.svh"

module chunk_head (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  dma_pkg::tile_cfg_t i_cfg,
	input  logic               i_req_rdy,
	output logic               o_req_ack,
	input  dma_pkg::tile_req_t i_req,
	output logic               o_chunk_rdy,
	input  logic               i_chunk_ack,
	output dma_pkg::chunk_t    o_chunk
);

//======================================================================
// Offset multiply
//======================================================================
logic                     full;
logic [`DMA_GADDR_BW-1:0] ofs_sext;
logic [`DMA_GADDR_BW-1:0] pitch_ext;
logic [`DMA_GADDR_BW-1:0] ofs_lines;

// Modulo 2^GADDR arithmetic keeps negative offsets correct
assign ofs_sext  = {{(`DMA_GADDR_BW-`DMA_ROW_BW){i_req.row_ofs[`DMA_ROW_BW-1]}}, i_req.row_ofs};
assign pitch_ext = {{(`DMA_GADDR_BW-`DMA_ROW_BW){1'b0}}, i_cfg.pitch};
assign ofs_lines = ofs_sext * pitch_ext;

//======================================================================
// One-entry buffer
//======================================================================
assign o_req_ack   = i_req_rdy && !full;
assign o_chunk_rdy = full;

always_ff @(posedge i_clk) begin
	if (!i_rst_n) begin
		full <= 1'b0;
	end else if (o_req_ack) begin
		full <= 1'b1;
	end else if (i_chunk_ack) begin
		full <= 1'b0;
	end
end

always_ff @(posedge i_clk) begin
	if (o_req_ack) begin
		o_chunk.start_addr <= i_cfg.base_addr + ofs_lines;
		o_chunk.row_ofs    <= i_req.row_ofs;
	end
end

// Chunk held until the looper takes it
a_chunk_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
	o_chunk_rdy && !i_chunk_ack |=> o_chunk_rdy && $stable(o_chunk));

endmodule

// ==== logic/chunk_addr_looper.sv ====
`include "dma_defs.svh"

module chunk_addr_looper (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  dma_pkg::tile_cfg_t       i_cfg,
	input  logic                     i_chunk_rdy,
	output logic                     o_chunk_ack,
	input  dma_pkg::chunk_t          i_chunk,
	output logic                     o_dramra_rdy,
	input  logic                     i_dramra_ack,
	output logic [`DMA_GADDR_BW-1:0] o_dramra,
	output logic                     o_cmd_rdy,
	input  logic                     i_cmd_ack,
	output dma_pkg::row_cmd_t        o_cmd
);

//======================================================================
// Row walker state
//======================================================================
logic                     busy;
logic [`DMA_TROW_BW-1:0]  trow;
logic [`DMA_ROW_BW-1:0]   row_idx;
logic [`DMA_GADDR_BW-1:0] line_addr;
logic                     cmd_done;
logic                     ra_done;
logic                     in_range;
logic                     cmd_hit;
logic                     ra_hit;
logic                     retire;
logic                     last_row;

// Negative rows have the sign bit set
assign in_range = !row_idx[`DMA_ROW_BW-1] && (row_idx < i_cfg.num_rows);
assign last_row = trow == `DMA_TROW_BW'(`DMA_TILE_ROWS-1);

assign o_chunk_ack = i_chunk_rdy && !busy;

//======================================================================
// Broadcast to DRAM address port and write collector
//======================================================================
assign o_cmd_rdy    = busy && !cmd_done;
assign o_dramra_rdy = busy && in_range && !ra_done;
assign o_dramra     = line_addr;

always_comb begin
	o_cmd.is_pad             = !in_range;
	o_cmd.trow               = trow;
	o_cmd.payload.fetch_addr = line_addr;
	if (!in_range) begin
		o_cmd.payload.pad.rsvd      = '0;
		o_cmd.payload.pad.pad_value = i_cfg.pad_value;
	end
end

// Pad rows have no DRAM branch to wait for
assign cmd_hit = i_cmd_ack || cmd_done;
assign ra_hit  = i_dramra_ack || ra_done || !in_range;
assign retire  = busy && cmd_hit && ra_hit;

always_ff @(posedge i_clk) begin
	if (!i_rst_n) begin
		busy     <= 1'b0;
		trow     <= '0;
		cmd_done <= 1'b0;
		ra_done  <= 1'b0;
	end else if (o_chunk_ack) begin
		busy     <= 1'b1;
		trow     <= '0;
		cmd_done <= 1'b0;
		ra_done  <= 1'b0;
	end else if (retire) begin
		busy     <= !last_row;
		trow     <= trow + 1'b1;
		cmd_done <= 1'b0;
		ra_done  <= 1'b0;
	end else begin
		cmd_done <= cmd_done || i_cmd_ack;
		ra_done  <= ra_done || i_dramra_ack;
	end
end

// Running row index and line address
always_ff @(posedge i_clk) begin
	if (o_chunk_ack) begin
		row_idx   <= i_chunk.row_ofs;
		line_addr <= i_chunk.start_addr;
	end else if (retire) begin
		row_idx   <= row_idx + 1'b1;
		line_addr <= line_addr + {{(`DMA_GADDR_BW-`DMA_ROW_BW){1'b0}}, i_cfg.pitch};
	end
end

// A pending DRAM request stays on its fetch row until it is acked
a_ra_fetch_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
	o_dramra_rdy && !i_dramra_ack |=> o_dramra_rdy && !o_cmd.is_pad && $stable(o_dramra));

endmodule

// ==== logic/sram_write_collector.sv ====
`include "dma_defs.svh"

module sram_write_collector (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  dma_pkg::tile_cfg_t i_cfg,
	input  logic               i_cmd_rdy,
	output logic               o_cmd_ack,
	input  dma_pkg::row_cmd_t  i_cmd,
	input  logic               i_dramrd_rdy,
	output logic               o_dramrd_ack,
	input  dma_pkg::dma_line_t i_dramrd,
	output logic               o_sram_we,
	output dma_pkg::sram_wr_t  o_sram_wr
);

//======================================================================
// Pair commands with DRAM data
//======================================================================
dma_pkg::dma_line_t         src_line;
dma_pkg::dma_line_t         swz_line;
logic [`DMA_LINE_IDX_BW-1:0] swz_sel;

// Pads go at once and fetches wait for their line
assign o_cmd_ack    = i_cmd_rdy && (i_cmd.is_pad || i_dramrd_rdy);
assign o_dramrd_ack = i_cmd_rdy && !i_cmd.is_pad && i_dramrd_rdy;

always_comb begin
	if (i_cmd.is_pad) begin
		src_line = {`DMA_LINE_WORDS{i_cmd.payload.pad.pad_value}};
	end else begin
		src_line = i_dramrd;
	end
end

//======================================================================
// Write butterfly
//======================================================================
// Word j lands in bank j ^ (trow mod LINE_WORDS)
assign swz_sel = i_cfg.xor_en ? i_cmd.trow[`DMA_LINE_IDX_BW-1:0] : '0;

always_comb begin
	swz_line = src_line;
	for (int j = 0; j < `DMA_LINE_WORDS; j++) begin
		swz_line[`DMA_LINE_IDX_BW'(j) ^ swz_sel] = src_line[j];
	end
end

//======================================================================
// Registered SRAM write
//======================================================================
always_ff @(posedge i_clk) begin
	if (!i_rst_n) begin
		o_sram_we <= 1'b0;
	end else begin
		o_sram_we <= o_cmd_ack;
	end
end

always_ff @(posedge i_clk) begin
	if (o_cmd_ack) begin
		o_sram_wr.trow <= i_cmd.trow;
		o_sram_wr.data <= swz_line;
	end
end

// A fetch command waits unchanged until its DRAM line arrives
a_fetch_wait: assert property (@(posedge i_clk) disable iff (!i_rst_n)
	i_cmd_rdy && !i_cmd.is_pad && !o_cmd_ack |=> i_cmd_rdy && $stable(i_cmd));

endmodule

// ==== logic/dma_pipeline.sv ====
`include "dma_defs.svh"

module dma_pipeline (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  dma_pkg::tile_cfg_t       i_cfg,
	// Tile request
	input  logic                     i_req_rdy,
	output logic                     o_req_ack,
	input  dma_pkg::tile_req_t       i_req,
	// DRAM read address
	output logic                     o_dramra_rdy,
	input  logic                     i_dramra_ack,
	output logic [`DMA_GADDR_BW-1:0] o_dramra,
	// DRAM read data
	input  logic                     i_dramrd_rdy,
	output logic                     o_dramrd_ack,
	input  dma_pkg::dma_line_t       i_dramrd,
	// SRAM write
	output logic                     o_sram_we,
	output dma_pkg::sram_wr_t        o_sram_wr
);

logic              chunk_rdy;
logic              chunk_ack;
dma_pkg::chunk_t   chunk;
logic              cmd_rdy;
logic              cmd_ack;
dma_pkg::row_cmd_t cmd;

chunk_head u_chunk_head (
	.i_clk       (i_clk),
	.i_rst_n     (i_rst_n),
	.i_cfg       (i_cfg),
	.i_req_rdy   (i_req_rdy),
	.o_req_ack   (o_req_ack),
	.i_req       (i_req),
	.o_chunk_rdy (chunk_rdy),
	.i_chunk_ack (chunk_ack),
	.o_chunk     (chunk)
);

chunk_addr_looper u_looper (
	.i_clk        (i_clk),
	.i_rst_n      (i_rst_n),
	.i_cfg        (i_cfg),
	.i_chunk_rdy  (chunk_rdy),
	.o_chunk_ack  (chunk_ack),
	.i_chunk      (chunk),
	.o_dramra_rdy (o_dramra_rdy),
	.i_dramra_ack (i_dramra_ack),
	.o_dramra     (o_dramra),
	.o_cmd_rdy    (cmd_rdy),
	.i_cmd_ack    (cmd_ack),
	.o_cmd        (cmd)
);

sram_write_collector u_swc (
	.i_clk        (i_clk),
	.i_rst_n      (i_rst_n),
	.i_cfg        (i_cfg),
	.i_cmd_rdy    (cmd_rdy),
	.o_cmd_ack    (cmd_ack),
	.i_cmd        (cmd),
	.i_dramrd_rdy (i_dramrd_rdy),
	.o_dramrd_ack (o_dramrd_ack),
	.i_dramrd     (i_dramrd),
	.o_sram_we    (o_sram_we),
	.o_sram_wr    (o_sram_wr)
);

endmodule

// ==== verif/tb_clock_gen.sv ====
module tb_clock_gen (
	output logic o_clk,
	output logic o_rst_n
);

initial begin
	o_clk = 1'b0;
	forever #4 o_clk = ~o_clk;
end

// Reset held low for eight rising edges
initial begin
	o_rst_n = 1'b0;
	repeat (8) @(posedge o_clk);
	#1;
	o_rst_n = 1'b1;
end

endmodule

// ==== verif/dma_pipeline_tb.sv ====
`include "dma_defs.svh"

module dma_pipeline_tb;

localparam int BASE     = 'h100;
localparam int PITCH    = 3;
localparam int NUM_ROWS = 10;
localparam int MAX_WAIT = 20000;

logic                     clk;
logic                     rst_n;
dma_pkg::tile_cfg_t       cfg;
logic                     req_rdy;
logic                     req_ack;
dma_pkg::tile_req_t       req;
logic                     dramra_rdy;
logic                     dramra_ack;
logic [`DMA_GADDR_BW-1:0] dramra;
logic                     dramrd_rdy;
logic                     dramrd_ack;
dma_pkg::dma_line_t       dramrd;
logic                     sram_we;
dma_pkg::sram_wr_t        sram_wr;

//======================================================================
// Scoreboard and DRAM model state
//======================================================================
logic [`DMA_GADDR_BW-1:0] exp_ra_q[$];
logic [`DMA_GADDR_BW-1:0] dram_q[$];
dma_pkg::sram_wr_t        exp_wr_q[$];
logic [`DMA_GADDR_BW-1:0] ra_held;
logic                     ra_stalled = 1'b0;
logic                     req_fire = 1'b0;
logic                     rd_fire = 1'b0;
logic [31:0]              lfsr_state = 32'hcc62_53c1;
int                       tiles_sent = 0;
int                       tile_limit = 0;

tb_clock_gen u_clk_gen (.o_clk(clk), .o_rst_n(rst_n));

dma_pipeline dut (
	.i_clk        (clk),
	.i_rst_n      (rst_n),
	.i_cfg        (cfg),
	.i_req_rdy    (req_rdy),
	.o_req_ack    (req_ack),
	.i_req        (req),
	.o_dramra_rdy (dramra_rdy),
	.i_dramra_ack (dramra_ack),
	.o_dramra     (dramra),
	.i_dramrd_rdy (dramrd_rdy),
	.o_dramrd_ack (dramrd_ack),
	.i_dramrd     (dramrd),
	.o_sram_we    (sram_we),
	.o_sram_wr    (sram_wr)
);

// Galois LFSR stepped once per bit taken
function automatic logic take_bit();
	lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
	return lfsr_state[0];
endfunction

// Word j of DRAM line a holds the low bits of a*4+j
function automatic dma_pkg::dma_line_t model_line(input logic [`DMA_GADDR_BW-1:0] addr);
	dma_pkg::dma_line_t line;
	for (int j = 0; j < `DMA_LINE_WORDS; j++) begin
		line[j] = `DMA_DATA_BW'(addr * 4 + j);
	end
	return line;
endfunction

// DRAM requests and SRAM writes that one tile must produce
function automatic void expect_tile(input int ofs);
	dma_pkg::dma_line_t       src;
	dma_pkg::sram_wr_t        wr;
	logic [`DMA_GADDR_BW-1:0] addr;
	for (int t = 0; t < `DMA_TILE_ROWS; t++) begin
		if (ofs + t >= 0 && ofs + t < NUM_ROWS) begin
			addr = `DMA_GADDR_BW'(BASE + (ofs + t) * PITCH);
			exp_ra_q.push_back(addr);
			src = model_line(addr);
		end else begin
			src = {`DMA_LINE_WORDS{cfg.pad_value}};
		end
		wr.trow = `DMA_TROW_BW'(t);
		for (int j = 0; j < `DMA_LINE_WORDS; j++) begin
			wr.data[cfg.xor_en ? (j ^ (t % `DMA_LINE_WORDS)) : j] = src[j];
		end
		exp_wr_q.push_back(wr);
	end
endfunction

task automatic flag_mismatch(input string msg);
	$display("mismatch at %0t: %s", $time, msg);
	$display("STATUS: FAIL");
	$fatal(1, "scoreboard check failed");
endtask

task automatic abort_run(input string msg);
	$display("error at %0t: %s", $time, msg);
	$display("STATUS: FAIL");
	$fatal(1, "run aborted");
endtask

// One clock of stimulus driven just after the rising edge
task automatic step_cycle();
	logic [4:0] r;
	@(posedge clk);
	#1;
	dramra_ack = take_bit();
	// A raised data line stays until the collector takes it
	if (!dramrd_rdy || rd_fire) begin
		dramrd_rdy = dram_q.size() > 0 && take_bit();
		if (dramrd_rdy) begin
			dramrd = model_line(dram_q[0]);
		end
	end
	if (req_rdy && req_fire) begin
		req_rdy = 1'b0;
		tiles_sent++;
	end else if (!req_rdy && tiles_sent < tile_limit && take_bit()) begin
		for (int i = 0; i < 5; i++) begin
			r[i] = take_bit();
		end
		// Offsets from -10 to 21 reach above and below the matrix
		req.row_ofs = `DMA_ROW_BW'(int'(r) - 10);
		expect_tile(int'(r) - 10);
		req_rdy = 1'b1;
	end
endtask

task automatic run_until_drained(input int limit);
	int cycles;
	cycles = 0;
	tile_limit = limit;
	while (tiles_sent < limit || exp_wr_q.size() > 0) begin
		if (cycles == MAX_WAIT) abort_run("timeout, tiles did not drain");
		step_cycle();
		cycles++;
	end
endtask

//======================================================================
// Response checks at the falling edge
//======================================================================
always @(negedge clk) begin
	if (rst_n) begin
		req_fire = req_rdy && req_ack;
		rd_fire  = dramrd_rdy && dramrd_ack;
		if (ra_stalled) begin
			assert (dramra_rdy && dramra == ra_held)
				else flag_mismatch($sformatf("o_dramra %h dropped while stalled", ra_held));
		end
		if (dramra_rdy && dramra_ack) begin
			assert (exp_ra_q.size() > 0) else abort_run("unexpected DRAM read request");
			assert (dramra == exp_ra_q[0])
				else flag_mismatch($sformatf("o_dramra %h, expected %h", dramra, exp_ra_q[0]));
			void'(exp_ra_q.pop_front());
			dram_q.push_back(dramra);
		end
		ra_stalled = dramra_rdy && !dramra_ack;
		ra_held    = dramra;
		if (rd_fire) begin
			void'(dram_q.pop_front());
		end
		if (sram_we) begin
			assert (exp_wr_q.size() > 0) else abort_run("SRAM write with no row pending");
			assert (sram_wr == exp_wr_q[0])
				else flag_mismatch($sformatf("SRAM row %0d data %h, expected row %0d data %h",
					sram_wr.trow, sram_wr.data, exp_wr_q[0].trow, exp_wr_q[0].data));
			void'(exp_wr_q.pop_front());
		end
	end
end

initial begin
	int cycles;
	cfg.base_addr = `DMA_GADDR_BW'(BASE);
	cfg.pitch     = `DMA_ROW_BW'(PITCH);
	cfg.num_rows  = `DMA_ROW_BW'(NUM_ROWS);
	cfg.pad_value = 16'h5a5a;
	cfg.xor_en    = 1'b0;
	req_rdy       = 1'b0;
	req           = '0;
	dramra_ack    = 1'b0;
	dramrd_rdy    = 1'b0;
	dramrd        = '0;
	cycles        = 0;
	while (rst_n !== 1'b1) begin
		if (cycles == 100) abort_run("reset was never released");
		@(posedge clk);
		cycles++;
	end
	@(negedge clk);
	assert (!req_ack && !dramra_rdy && !dramrd_ack && !sram_we)
		else flag_mismatch("handshake output high after reset");
	// Swizzle enabled only once the first half has fully drained
	run_until_drained(20);
	cfg.xor_en = 1'b1;
	run_until_drained(40);
	if (exp_ra_q.size() == 0 && dram_q.size() == 0) begin
		$display("STATUS: PASS");
		$finish;
	end else begin
		abort_run("DRAM requests left over after the last write");
	end
end

endmodule

// ==== flist.f ====
+incdir+logic
logic/dma_pkg.sv
logic/chunk_head.sv
logic/chunk_addr_looper.sv
logic/sram_write_collector.sv
logic/dma_pipeline.sv
verif/tb_clock_gen.sv
verif/dma_pipeline_tb.sv

// ==== Makefile ====
# Verilator build and run of the DMA tile fetcher testbench

VERILATOR ?= verilator
TOP       ?= dma_pipeline_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

PASS_MSG  := STATUS: PASS

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Override VERILATOR, TOP, FLIST, OBJ_DIR, LOG or VFLAGS on the command line"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
